/* red_ctrl.sv */
`timescale 1ns/1ps

module red_ctrl (
    input  logic       clk,
    input  logic       nrst,
    input  logic [2:0] op_instr,
    input  logic [1:0] sew,
    input  logic [1:0] lmul,
    red_ctrl_if.ctrl   bus,
    output logic       done
);
    import v_red_pkg::*;

    lvl_t lvl;       // current tree level
    lvl_t last_lvl;

    // ----------------------------------------
    // Operation decode
    // ----------------------------------------
    assign bus.op   = (op_instr != 3'd0) ? RED_MAX : RED_SUM;  // any nonzero code is max
    assign bus.sew  = sew_e'(sew);
    assign bus.lmul = lmul_e'(lmul);

    // Pass length is log2(N) = LAST_BASE + 1 + lmul - sew
    assign last_lvl = lvl_t'(LAST_BASE) + lvl_t'(lmul) - lvl_t'(sew);

    assign bus.first = (lvl == '0);
    assign bus.last  = (lvl == last_lvl);

    // ----------------------------------------
    // Level counter
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            lvl  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= bus.last;  // same edge that loads result
            if (bus.last)
            begin
                lvl <= '0;
            end
            else
            begin
                lvl <= lvl + 1'b1;
            end
        end
    end

    // Reserved codes would give a zero or wrong pass length
    a_lmul_legal: assert property (
        @(posedge clk) disable iff (!nrst) lmul != 2'd3
    );

    a_sew_legal: assert property (
        @(posedge clk) disable iff (!nrst) sew != 2'd3
    );

    // Shortest pass is two levels
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!nrst) done |=> !done
    );

endmodule

/* red_ctrl_if.sv */
`timescale 1ns/1ps

interface red_ctrl_if;
    import v_red_pkg::*;

    red_op_e op;     // decoded operation
    sew_e    sew;
    lmul_e   lmul;
    logic    first;  // level 0 of a pass
    logic    last;   // final level of a pass

    modport ctrl (
        output op,
        output sew,
        output lmul,
        output first,
        output last
    );

    // Datapath only follows the counter
    modport dp (
        input op,
        input sew,
        input lmul,
        input first,
        input last
    );

endinterface

/* red_datapath.sv */
`timescale 1ns/1ps

module red_datapath (
    input  logic               clk,
    input  logic               nrst,
    input  v_red_pkg::vgroup_t group,
    input  v_red_pkg::scalar_t vec_regA,
    red_ctrl_if.dp             bus,
    output v_red_pkg::scalar_t result
);
    import v_red_pkg::*;

    vreg_t   id_reg;     // identity pattern, one register wide
    vgroup_t operand;
    work_t   folded;
    work_t   work_q;
    vgroup_t merge_in;
    work_t   merge_out;
    scalar_t merged;

    // ----------------------------------------
    // Operand build
    // ----------------------------------------
    always_comb
    begin
        if (bus.op == RED_SUM)
        begin
            id_reg = SUM_ID;
        end
        else
        begin
            case (bus.sew)
                SEW16:   id_reg = MAX_ID_SEW16;
                SEW32:   id_reg = MAX_ID_SEW32;
                default: id_reg = MAX_ID_SEW8;
            endcase
        end
    end

    always_comb
    begin
        if (bus.first)
        begin
            operand[VLEN-1:0] = group[VLEN-1:0];
            operand[2*VLEN-1:VLEN] = (bus.lmul != LMUL1) ? group[2*VLEN-1:VLEN] : id_reg;
            operand[GROUP_W-1:2*VLEN] =
                (bus.lmul == LMUL4) ? group[GROUP_W-1:2*VLEN] : {2{id_reg}};
        end
        else
        begin
            // Dead lanes of work_q already hold identity values
            operand = {id_reg, id_reg, work_q};
        end
    end

    red_fold u_fold (
        .operand (operand),
        .sew     (bus.sew),
        .op      (bus.op),
        .folded  (folded)
    );

    always_ff @(posedge clk)
    begin
        work_q <= folded;
    end

    // ----------------------------------------
    // Scalar merge
    // ----------------------------------------
    // Element 0 is the tree result, element 1 the low element of vec_regA
    always_comb
    begin
        merge_in = {4{id_reg}};
        case (bus.sew)
            SEW16:
            begin
                merge_in[15:0]  = folded[15:0];
                merge_in[31:16] = vec_regA[15:0];
            end
            SEW32:
            begin
                merge_in[31:0]  = folded[31:0];
                merge_in[63:32] = vec_regA;
            end
            default:
            begin
                merge_in[7:0]  = folded[7:0];
                merge_in[15:8] = vec_regA[7:0];
            end
        endcase
    end

    red_fold u_merge (
        .operand (merge_in),
        .sew     (bus.sew),
        .op      (bus.op),
        .folded  (merge_out)
    );

    always_comb
    begin
        case (bus.sew)
            SEW16:   merged = {16'd0, merge_out[15:0]};
            SEW32:   merged = merge_out[XLEN-1:0];
            default: merged = {24'd0, merge_out[7:0]};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            result <= '0;
        end
        else if (bus.last)
        begin
            result <= merged;  // holds until the next pass ends
        end
    end

    // A pass always has at least two levels
    a_first_last: assert property (
        @(posedge clk) disable iff (!nrst) !(bus.first && bus.last)
    );

endmodule

/* red_fold.sv */
`timescale 1ns/1ps

module red_fold (
    input  v_red_pkg::vgroup_t operand,
    input  v_red_pkg::sew_e    sew,
    input  v_red_pkg::red_op_e op,
    output v_red_pkg::work_t   folded
);
    import v_red_pkg::*;

    // One candidate per element width, index = sew code
    logic [2:0][WORK_W-1:0] fold_w;

    // ----------------------------------------
    // Pairwise combine
    // ----------------------------------------
    for (genvar w = 0; w < 3; w++)
    begin : g_width
        // Element width is 8 << w, a pair spans 16 << w
        for (genvar i = 0; i < WORK_W / (8 << w); i++)
        begin : g_pair
            logic [(8 << w)-1:0] lo;
            logic [(8 << w)-1:0] hi;

            assign lo = operand[(16 << w) * i +: (8 << w)];                // element 2i
            assign hi = operand[(16 << w) * i + (8 << w) +: (8 << w)];     // element 2i+1

            // Wrapping sum, or signed max with lo kept on a tie
            assign fold_w[w][(8 << w) * i +: (8 << w)] =
                (op == RED_SUM)              ? lo + hi :
                ($signed(lo) >= $signed(hi)) ? lo      : hi;
        end
    end

    // ----------------------------------------
    // Width select
    // ----------------------------------------
    always_comb
    begin
        case (sew)
            SEW16:   folded = fold_w[1];
            SEW32:   folded = fold_w[2];
            default: folded = fold_w[0];
        endcase
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_v_red -f v_red.f -o sim_v_red

out=$(./obj_dir/sim_v_red)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
else
    exit 1
fi

/* tb_v_red.sv */
`timescale 1ns/1ps

module tb_v_red;
    import v_red_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam logic [31:0] SEED         = 32'hac37c2d2;
    localparam int          N_DIRECTED   = 50;
    localparam int          N_RANDOM     = 200;
    localparam int          TOTAL_PASSES = 1 + N_DIRECTED + N_RANDOM;
    // 7 cycles covers the longest pass
    localparam int          WATCHDOG_NS  = TOTAL_PASSES * 7 * CLK_PERIOD + 1000;

    logic       clk;
    logic       nrst;
    logic [2:0] op_instr;
    logic [1:0] sew;
    logic [1:0] lmul;
    vreg_t      vec_regB_1;
    vreg_t      vec_regB_2;
    vreg_t      vec_regB_3;
    vreg_t      vec_regB_4;
    scalar_t    vec_regA;
    logic       done;
    scalar_t    result;

    int value_errors;
    int timing_errors;
    int passes_checked;
    int passes_driven;

    v_red dut_i (
        .clk (clk), .nrst (nrst), .op_instr (op_instr), .sew (sew), .lmul (lmul),
        .vec_regB_1 (vec_regB_1), .vec_regB_2 (vec_regB_2),
        .vec_regB_3 (vec_regB_3), .vec_regB_4 (vec_regB_4),
        .vec_regA (vec_regA), .done (done), .result (result)
    );

    v_red_checker chk_i (
        .clk (clk), .nrst (nrst), .op_instr (op_instr), .sew (sew), .lmul (lmul),
        .vec_regB_1 (vec_regB_1), .vec_regB_2 (vec_regB_2),
        .vec_regB_3 (vec_regB_3), .vec_regB_4 (vec_regB_4),
        .vec_regA (vec_regA), .done (done), .result (result),
        .value_errors (value_errors), .timing_errors (timing_errors),
        .passes_checked (passes_checked)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic logic [31:0] elem_mask(input logic [1:0] sw);
        case (sw)
            2'd1:    return 32'h0000_ffff;
            2'd2:    return 32'hffff_ffff;
            default: return 32'h0000_00ff;
        endcase
    endfunction

    function automatic logic [31:0] sign_bit(input logic [1:0] sw);
        return elem_mask(sw) ^ (elem_mask(sw) >> 1);
    endfunction

    // Same value in every element of a register
    function automatic vreg_t fill_elem(input logic [1:0] sw, input logic [31:0] val);
        vreg_t r;
        int    ew;
        r  = '0;
        ew = 8 << sw;
        for (int k = 0; k < VLEN / ew; k++)
        begin
            r = r | (vreg_t'(val & elem_mask(sw)) << (k * ew));
        end
        return r;
    endfunction

    function automatic vreg_t rand_vreg();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Next inputs go in during the done cycle
    task automatic start_pass(
        input logic [2:0] op,
        input logic [1:0] sw,
        input logic [1:0] lm,
        input vreg_t      b1,
        input vreg_t      b2,
        input vreg_t      b3,
        input vreg_t      b4,
        input scalar_t    a
    );
        @(negedge clk);
        while (!done)
        begin
            @(negedge clk);
        end
        op_instr   = op;
        sew        = sw;
        lmul       = lm;
        vec_regB_1 = b1;
        vec_regB_2 = b2;
        vec_regB_3 = b3;
        vec_regB_4 = b4;
        vec_regA   = a;
        passes_driven++;
    endtask

    task automatic rand_pass(input logic [2:0] op, input logic [1:0] sw, input logic [1:0] lm);
        start_pass(op, sw, lm, rand_vreg(), rand_vreg(), rand_vreg(), rand_vreg(), $urandom);
    endtask

    // All elements negative
    task automatic neg_pass(input logic [1:0] sw, input logic [1:0] lm, input scalar_t a);
        start_pass(3'd1, sw, lm,
                   rand_vreg() | fill_elem(sw, sign_bit(sw)),
                   rand_vreg() | fill_elem(sw, sign_bit(sw)),
                   rand_vreg() | fill_elem(sw, sign_bit(sw)),
                   rand_vreg() | fill_elem(sw, sign_bit(sw)), a);
    endtask

    initial
    begin
        logic [31:0] seed_val;
        seed_val   = $urandom(SEED);
        nrst       = 1'b0;
        op_instr   = 3'd0;
        sew        = 2'd0;
        lmul       = 2'd0;
        vec_regB_1 = '0;
        vec_regB_2 = '0;
        vec_regB_3 = '0;
        vec_regB_4 = '0;
        vec_regA   = '0;
        passes_driven = 1;  // all-zero pass out of reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        // ----------------------------------------
        // Directed passes
        // ----------------------------------------
        for (int s = 0; s < 3; s++)
        begin
            for (int l = 0; l < 3; l++)
            begin
                rand_pass(3'd0, 2'(s), 2'(l));
                rand_pass(3'd1, 2'(s), 2'(l));
                neg_pass(2'(s), 2'(l), $urandom | sign_bit(2'(s)));
                // vec_regA beats every element
                neg_pass(2'(s), 2'(l), ($urandom & ~elem_mask(2'(s))) | (elem_mask(2'(s)) >> 1));
            end
        end

        // Registers beyond LMUL1 hold extreme values
        for (int s = 0; s < 3; s++)
        begin
            start_pass(3'd0, 2'(s), 2'd0, rand_vreg(), '1, '1, '1, $urandom);
            start_pass(3'd1, 2'(s), 2'd0, rand_vreg() | fill_elem(2'(s), sign_bit(2'(s))),
                       fill_elem(2'(s), elem_mask(2'(s)) >> 1),
                       fill_elem(2'(s), elem_mask(2'(s)) >> 1),
                       fill_elem(2'(s), elem_mask(2'(s)) >> 1),
                       $urandom | sign_bit(2'(s)));
        end

        for (int o = 0; o < 8; o++)
        begin
            rand_pass(3'(o), 2'($urandom_range(2, 0)), 2'($urandom_range(2, 0)));
        end

        // ----------------------------------------
        // Random passes
        // ----------------------------------------
        repeat (N_RANDOM)
        begin
            rand_pass(3'($urandom_range(7, 0)), 2'($urandom_range(2, 0)),
                      2'($urandom_range(2, 0)));
        end

        // Last pass ends and gets checked
        @(negedge clk);
        while (!done)
        begin
            @(negedge clk);
        end
        @(negedge clk);

        if (passes_checked < passes_driven)
            $display("Only %0d of %0d passes reached done", passes_checked, passes_driven);
        $display("Passes checked %0d, value errors %0d, timing errors %0d",
                 passes_checked, value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0 && passes_checked >= passes_driven)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d passes checked",
                 WATCHDOG_NS, passes_checked);
        $display("Something failed");
        $finish;
    end

endmodule

/* v_red.f */
v_red_pkg.sv
red_ctrl_if.sv
red_fold.sv
red_ctrl.sv
red_datapath.sv
v_red.sv
v_red_checker.sv
tb_v_red.sv

/* v_red.sv */
`timescale 1ns/1ps

module v_red (
    input  logic               clk,
    input  logic               nrst,
    input  logic [2:0]         op_instr,
    input  logic [1:0]         sew,
    input  logic [1:0]         lmul,
    input  v_red_pkg::vreg_t   vec_regB_1,
    input  v_red_pkg::vreg_t   vec_regB_2,
    input  v_red_pkg::vreg_t   vec_regB_3,
    input  v_red_pkg::vreg_t   vec_regB_4,
    input  v_red_pkg::scalar_t vec_regA,
    output logic               done,
    output v_red_pkg::scalar_t result
);
    import v_red_pkg::*;

    vgroup_t group;

    red_ctrl_if ctrl_bus ();

    // Register group, vec_regB_1 in the low lanes
    assign group = {vec_regB_4, vec_regB_3, vec_regB_2, vec_regB_1};

    // ----------------------------------------
    // Controller and datapath
    // ----------------------------------------
    red_ctrl u_ctrl (
        .clk      (clk),
        .nrst     (nrst),
        .op_instr (op_instr),
        .sew      (sew),
        .lmul     (lmul),
        .bus      (ctrl_bus),
        .done     (done)
    );

    red_datapath u_dp (
        .clk      (clk),
        .nrst     (nrst),
        .group    (group),
        .vec_regA (vec_regA),
        .bus      (ctrl_bus),
        .result   (result)
    );

endmodule

/* v_red_checker.sv */
`timescale 1ns/1ps

module v_red_checker (
    input  logic               clk,
    input  logic               nrst,
    input  logic [2:0]         op_instr,
    input  logic [1:0]         sew,
    input  logic [1:0]         lmul,
    input  v_red_pkg::vreg_t   vec_regB_1,
    input  v_red_pkg::vreg_t   vec_regB_2,
    input  v_red_pkg::vreg_t   vec_regB_3,
    input  v_red_pkg::vreg_t   vec_regB_4,
    input  v_red_pkg::scalar_t vec_regA,
    input  logic               done,
    input  v_red_pkg::scalar_t result,
    output int                 value_errors,
    output int                 timing_errors,
    output int                 passes_checked
);
    import v_red_pkg::*;

    scalar_t exp_q;      // reference for the pass in flight
    scalar_t held_q;     // result since the previous done
    int      len_q;
    int      gap;        // cycles since the previous done
    logic    done_q;
    logic    after_rst;

    // Sign extend an element of width ew
    function automatic int elem_signed(input logic [31:0] x, input int ew);
        logic [31:0] sh;
        sh = x << (32 - ew);
        return int'(sh) >>> (32 - ew);
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic scalar_t reduce_ref(
        input logic [2:0] op_code,
        input logic [1:0] sew_code,
        input logic [1:0] lmul_code,
        input vgroup_t    grp,
        input scalar_t    a
    );
        int          ew;
        int          n;
        logic [31:0] mask;
        logic [31:0] elem;
        logic [31:0] acc;
        ew   = 8 << sew_code;
        n    = (VLEN << lmul_code) / ew;
        mask = (ew == 32) ? 32'hffff_ffff : (32'h1 << ew) - 32'h1;
        acc  = a & mask;  // low element of vec_regA
        for (int k = 0; k < n; k++)
        begin
            elem = 32'(grp >> (k * ew)) & mask;
            if (op_code == 3'd0)
                acc = (acc + elem) & mask;  // wraps in the element width
            else if (elem_signed(elem, ew) > elem_signed(acc, ew))
                acc = elem;
        end
        return acc;
    endfunction

    // Tree depth with one level per halving
    function automatic int pass_len(input logic [1:0] sew_code, input logic [1:0] lmul_code);
        int n;
        int len;
        n   = (VLEN << lmul_code) / (8 << sew_code);
        len = 0;
        while (n > 1)
        begin
            n   = n / 2;
            len = len + 1;
        end
        return len;
    endfunction

    initial
    begin
        value_errors   = 0;
        timing_errors  = 0;
        passes_checked = 0;
    end

    // ----------------------------------------
    // Compare on every done
    // ----------------------------------------
    always @(posedge clk)
    begin
        if (!nrst)
        begin
            gap       <= 0;
            held_q    <= '0;
            done_q    <= 1'b0;
            after_rst <= 1'b1;
        end
        else
        begin
            if (after_rst && done !== 1'b0)
            begin
                $display("CHECK FAILED at %0t: done expected 0, actual %b", $time, done);
                value_errors++;
            end
            after_rst <= 1'b0;

            if (done && done_q)
            begin
                $display("done stayed high for two cycles in a row at %0t", $time);
                timing_errors++;
            end

            if (done)
            begin
                passes_checked++;
                if (result !== exp_q)
                begin
                    $display("CHECK FAILED at %0t: result expected %h, actual %h",
                             $time, exp_q, result);
                    value_errors++;
                end
                // First pass starts on the first edge out of reset
                if (gap != len_q)
                begin
                    $display("Pass length wrong at %0t: done pulses %0d cycles apart, expected %0d",
                             $time, gap, len_q);
                    timing_errors++;
                end
                gap    <= 1;
                held_q <= result;
            end
            else
            begin
                // Result holds between done pulses
                if (result !== held_q)
                begin
                    $display("CHECK FAILED at %0t: result expected %h, actual %h",
                             $time, held_q, result);
                    value_errors++;
                end
                gap <= gap + 1;
            end

            done_q <= done;
            // Inputs are still those of the running pass here
            exp_q  <= reduce_ref(op_instr, sew, lmul,
                                 {vec_regB_4, vec_regB_3, vec_regB_2, vec_regB_1}, vec_regA);
            len_q  <= pass_len(sew, lmul);
        end
    end

endmodule

/* v_red_pkg.sv */
package v_red_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int VLEN    = 128;
    localparam int GROUP_W = 4 * VLEN;       // lmul 4 group
    localparam int WORK_W  = GROUP_W / 2;    // after the first fold
    localparam int XLEN    = 32;
    localparam int LVL_W   = 3;

    // Last level index for SEW8 LMUL1, shifted by lmul and sew codes
    localparam int LAST_BASE = $clog2(VLEN / 8) - 1;

    typedef logic [VLEN-1:0]    vreg_t;
    typedef logic [GROUP_W-1:0] vgroup_t;
    typedef logic [WORK_W-1:0]  work_t;
    typedef logic [XLEN-1:0]    scalar_t;
    typedef logic [LVL_W-1:0]   lvl_t;

    // ----------------------------------------
    // Operation codes
    // ----------------------------------------
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_e;

    typedef enum logic [1:0] {
        LMUL1 = 2'd0,
        LMUL2 = 2'd1,
        LMUL4 = 2'd2
    } lmul_e;

    typedef enum logic {
        RED_SUM = 1'b0,
        RED_MAX = 1'b1
    } red_op_e;

    // ----------------------------------------
    // Identity registers
    // ----------------------------------------
    localparam vreg_t SUM_ID = '0;

    // Most negative value in every element
    localparam vreg_t MAX_ID_SEW8  = {16{8'h80}};
    localparam vreg_t MAX_ID_SEW16 = {8{16'h8000}};
    localparam vreg_t MAX_ID_SEW32 = {4{32'h8000_0000}};

endpackage
